// ==== verilog/bp_params.svh ====
// branch predictor sizing macros: address, queue, table index and history widths
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// width of fetch and commit addresses
`define BP_PC_W 32

// update queue entries and pointer width
// the queue adds one wrap bit on top of the pointer
`define BP_QUEUE_DEPTH 32
`define BP_QUEUE_PTR_W 5

// counter table index, 512 entries
`define BP_BHT_IDX_W 9

// global taken history, index uses the upper two bits
`define BP_HIST_W 3

`endif

// ==== verilog/bp_pkg.sv ====
// branch predictor types: counter state enum and update queue entry struct
`include "bp_params.svh"

package bp_pkg;

	// ========================================================================
	// two bit saturating counter
	// ========================================================================

	// encoding follows stepping order, taken moves up, not-taken moves down
	// weak_t and strong_t predict taken
	typedef enum logic [1:0] {
		strong_nt = 2'd0,
		weak_nt   = 2'd1,
		weak_t    = 2'd2,
		strong_t  = 2'd3
	} bht_state_t;

	// ========================================================================
	// retired branch update
	// ========================================================================

	// one 32-bit word per queue entry
	// address bit 0 is never needed, so the taken bit takes its place
	typedef struct packed {
		logic [`BP_PC_W-1:1] pc;
		logic                taken;
	} bp_update_t;

endpackage

// ==== verilog/bp_commit_filter.sv ====
// commit filter: registers two retiring branches, drops shadowed slot 1, compacts
`timescale 1ns/10ps
`include "bp_params.svh"

module bp_commit_filter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 commit0_valid,
	input  logic [`BP_PC_W-1:0]  commit0_pc,
	input  logic                 commit0_taken,
	input  logic                 commit1_valid,
	input  logic [`BP_PC_W-1:0]  commit1_pc,
	input  logic                 commit1_taken,
	output logic                 upd0_valid,
	output logic                 upd1_valid,
	output bp_pkg::bp_update_t   upd0,
	output bp_pkg::bp_update_t   upd1
);

	// packed forms of the two commit slots
	bp_pkg::bp_update_t slot0;
	bp_pkg::bp_update_t slot1;
	// slot 1 survives only if slot 0 does not redirect
	logic               slot1_keep;

	assign slot0.pc    = commit0_pc[`BP_PC_W-1:1];
	assign slot0.taken = commit0_taken;
	assign slot1.pc    = commit1_pc[`BP_PC_W-1:1];
	assign slot1.taken = commit1_taken;

	// a taken branch in slot 0 means slot 1 was never on the real path
	assign slot1_keep = commit1_valid && !(commit0_valid && commit0_taken);

	// ========================================================================
	// valid strobes
	// ========================================================================

	// output slot 0 holds whichever branch survives first
	// output slot 1 only when both survive, so upd1_valid implies upd0_valid
	always_ff @(posedge clk) begin
		if (rst) begin
			upd0_valid <= 1'b0;
			upd1_valid <= 1'b0;
		end else begin
			upd0_valid <= commit0_valid || slot1_keep;
			upd1_valid <= commit0_valid && slot1_keep;
		end
	end

	// ========================================================================
	// payload
	// ========================================================================

	// lone slot-1 branch moves down so the queue writes contiguously
	always_ff @(posedge clk) begin
		if (commit0_valid) begin
			upd0 <= slot0;
		end else begin
			upd0 <= slot1;
		end
		upd1 <= slot1;
	end

endmodule

// ==== verilog/bp_update_queue.sv ====
// update queue: circular buffer with dual push, single gated pop, overflow drop flag
`timescale 1ns/10ps
`include "bp_params.svh"

module bp_update_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic                en,
	input  logic                upd0_valid,
	input  logic                upd1_valid,
	input  bp_pkg::bp_update_t  upd0,
	input  bp_pkg::bp_update_t  upd1,
	output logic                pop_valid,
	output bp_pkg::bp_update_t  pop_entry,
	output logic                update_dropped
);

	localparam int PW = `BP_QUEUE_PTR_W;
	// depth as a count, one bit wider than the slot index
	localparam logic [PW:0] DEPTH_CNT = `BP_QUEUE_DEPTH;

	// entry storage
	bp_pkg::bp_update_t mem [0:`BP_QUEUE_DEPTH-1];

	// pointers carry a wrap bit so full and empty differ
	logic [PW:0] head_ptr;
	logic [PW:0] tail_ptr;
	logic [PW:0] tail_ptr_inc;
	logic [PW:0] occupancy;
	logic [PW:0] free_cnt;
	logic        empty;
	logic        do_pop;
	logic        acc0;
	logic        acc1;
	logic [1:0]  push_cnt;

	assign occupancy    = tail_ptr - head_ptr;
	assign empty        = (occupancy == '0);
	// head only moves while the fetch side is enabled
	assign do_pop       = en && !empty;

	// a slot freed by this cycle's pop is free for this cycle's push
	assign free_cnt     = DEPTH_CNT - occupancy + {{PW{1'b0}}, do_pop};

	// slot 0 gets the first free entry, slot 1 needs a second one
	assign acc0         = upd0_valid && (free_cnt != '0);
	assign acc1         = upd1_valid && (free_cnt[PW:1] != '0);
	assign push_cnt     = {1'b0, acc0} + {1'b0, acc1};
	assign tail_ptr_inc = tail_ptr + 1'b1;

	// ========================================================================
	// push side
	// ========================================================================

	always_ff @(posedge clk) begin
		if (acc0) begin
			mem[tail_ptr[PW-1:0]] <= upd0;
		end
		if (acc1) begin
			mem[tail_ptr_inc[PW-1:0]] <= upd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tail_ptr       <= '0;
			update_dropped <= 1'b0;
		end else begin
			tail_ptr       <= tail_ptr + {{(PW-1){1'b0}}, push_cnt};
			// any valid entry left without room is lost
			update_dropped <= (upd0_valid && !acc0) || (upd1_valid && !acc1);
		end
	end

	// ========================================================================
	// pop side
	// ========================================================================

	// head entry goes out through registers, one per cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr  <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			if (do_pop) begin
				head_ptr <= head_ptr + 1'b1;
			end
		end
	end

	// payload register, reads the old entry even when the same slot is rewritten
	always_ff @(posedge clk) begin
		if (do_pop) begin
			pop_entry <= mem[head_ptr[PW-1:0]];
		end
	end

endmodule

// ==== verilog/bp_history_table.sv ====
// history table: 512 saturating counters, four fetch read ports, global history
`timescale 1ns/10ps
`include "bp_params.svh"

module bp_history_table (
	input  logic                clk,
	input  logic                rst,
	input  logic                en,
	input  logic                pop_valid,
	input  bp_pkg::bp_update_t  pop_entry,
	input  logic [`BP_PC_W-1:0] fetch_pc_a,
	input  logic [`BP_PC_W-1:0] fetch_pc_b,
	input  logic [`BP_PC_W-1:0] fetch_pc_c,
	input  logic [`BP_PC_W-1:0] fetch_pc_d,
	output logic                predict_taken_a,
	output logic                predict_taken_b,
	output logic                predict_taken_c,
	output logic                predict_taken_d
);

	localparam int IW = `BP_BHT_IDX_W;
	localparam int HW = `BP_HIST_W;
	localparam int ENTRIES = 1 << IW;
	// address bits in the index, the rest comes from history
	localparam int ABITS = IW - (HW - 1);

	bp_pkg::bht_state_t bht [0:ENTRIES-1];
	logic [HW-1:0]      ghist;

	logic [IW-1:0]      idx_upd;
	logic [IW-1:0]      idx_a;
	logic [IW-1:0]      idx_b;
	logic [IW-1:0]      idx_c;
	logic [IW-1:0]      idx_d;

	// ========================================================================
	// helpers
	// ========================================================================

	// address bits 8:2 followed by history bits 2:1
	function automatic logic [IW-1:0] bht_index(input logic [`BP_PC_W-1:1] addr,
			input logic [HW-1:0] hist);
		return {addr[ABITS+1:2], hist[HW-1:1]};
	endfunction

	// one saturating step toward the resolved direction
	function automatic bp_pkg::bht_state_t bht_step(input bp_pkg::bht_state_t cur,
			input logic taken);
		bp_pkg::bht_state_t nxt;
		nxt = cur;
		case (cur)
			bp_pkg::strong_nt: nxt = taken ? bp_pkg::weak_nt : bp_pkg::strong_nt;
			bp_pkg::weak_nt:   nxt = taken ? bp_pkg::weak_t : bp_pkg::strong_nt;
			bp_pkg::weak_t:    nxt = taken ? bp_pkg::strong_t : bp_pkg::weak_nt;
			bp_pkg::strong_t:  nxt = taken ? bp_pkg::strong_t : bp_pkg::weak_t;
			default:           nxt = bp_pkg::weak_nt;
		endcase
		return nxt;
	endfunction

	// upper half of the encoding is the taken side
	function automatic logic is_taken(input bp_pkg::bht_state_t st);
		return (st == bp_pkg::weak_t) || (st == bp_pkg::strong_t);
	endfunction

	// ========================================================================
	// read ports
	// ========================================================================

	assign idx_a = bht_index(fetch_pc_a[`BP_PC_W-1:1], ghist);
	assign idx_b = bht_index(fetch_pc_b[`BP_PC_W-1:1], ghist);
	assign idx_c = bht_index(fetch_pc_c[`BP_PC_W-1:1], ghist);
	assign idx_d = bht_index(fetch_pc_d[`BP_PC_W-1:1], ghist);

	// predictor disabled means fall through on every slot
	assign predict_taken_a = en && is_taken(bht[idx_a]);
	assign predict_taken_b = en && is_taken(bht[idx_b]);
	assign predict_taken_c = en && is_taken(bht[idx_c]);
	assign predict_taken_d = en && is_taken(bht[idx_d]);

	// ========================================================================
	// update
	// ========================================================================

	// indexed with the history as it stood before this update
	assign idx_upd = bht_index(pop_entry.pc, ghist);

	// pop_valid only rises while en is high
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < ENTRIES; i++) begin
				bht[i] <= bp_pkg::weak_nt;
			end
			ghist <= '0;
		end else if (pop_valid) begin
			bht[idx_upd] <= bht_step(bht[idx_upd], pop_entry.taken);
			// newest outcome enters at bit 0
			ghist <= {ghist[HW-2:0], pop_entry.taken};
		end
	end

endmodule

// ==== verilog/bp_predictor.sv ====
// branch direction predictor top: commit filter, update queue and history table
`timescale 1ns/10ps
`include "bp_params.svh"

module bp_predictor (
	input  logic                clk,
	input  logic                rst,
	input  logic                en,
	input  logic                commit0_valid,
	input  logic [`BP_PC_W-1:0] commit0_pc,
	input  logic                commit0_taken,
	input  logic                commit1_valid,
	input  logic [`BP_PC_W-1:0] commit1_pc,
	input  logic                commit1_taken,
	input  logic [`BP_PC_W-1:0] fetch_pc_a,
	input  logic [`BP_PC_W-1:0] fetch_pc_b,
	input  logic [`BP_PC_W-1:0] fetch_pc_c,
	input  logic [`BP_PC_W-1:0] fetch_pc_d,
	output logic                predict_taken_a,
	output logic                predict_taken_b,
	output logic                predict_taken_c,
	output logic                predict_taken_d,
	output logic                update_dropped
);

	// filter to queue
	logic               upd0_valid;
	logic               upd1_valid;
	bp_pkg::bp_update_t upd0;
	bp_pkg::bp_update_t upd1;
	// queue to table
	logic               pop_valid;
	bp_pkg::bp_update_t pop_entry;

	// retire side, one cycle
	bp_commit_filter i_bp_commit_filter (
		.clk(clk), .rst(rst),
		.commit0_valid(commit0_valid), .commit0_pc(commit0_pc),
		.commit0_taken(commit0_taken),
		.commit1_valid(commit1_valid), .commit1_pc(commit1_pc),
		.commit1_taken(commit1_taken),
		.upd0_valid(upd0_valid), .upd1_valid(upd1_valid),
		.upd0(upd0), .upd1(upd1)
	);

	// decouples dual retire from single update, stalls while en is low
	bp_update_queue i_bp_update_queue (
		.clk(clk), .rst(rst), .en(en),
		.upd0_valid(upd0_valid), .upd1_valid(upd1_valid),
		.upd0(upd0), .upd1(upd1),
		.pop_valid(pop_valid), .pop_entry(pop_entry),
		.update_dropped(update_dropped)
	);

	// fetch side reads, one update per cycle
	bp_history_table i_bp_history_table (
		.clk(clk), .rst(rst), .en(en),
		.pop_valid(pop_valid), .pop_entry(pop_entry),
		.fetch_pc_a(fetch_pc_a), .fetch_pc_b(fetch_pc_b),
		.fetch_pc_c(fetch_pc_c), .fetch_pc_d(fetch_pc_d),
		.predict_taken_a(predict_taken_a), .predict_taken_b(predict_taken_b),
		.predict_taken_c(predict_taken_c), .predict_taken_d(predict_taken_d)
	);

endmodule

// ==== sim/bp_tb.sv ====
// branch predictor testbench with lcg stimulus, reference model and per-cycle checks
`timescale 1ns/10ps
`include "bp_params.svh"

module bp_tb;

	localparam int RUN_CYCLES = 3000;
	// four phases plus reset and a margin for the last drain
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + 500;
	localparam int DEPTH = `BP_QUEUE_DEPTH;

	logic                clk;
	logic                rst;
	logic                en;
	logic                commit0_valid;
	logic [`BP_PC_W-1:0] commit0_pc;
	logic                commit0_taken;
	logic                commit1_valid;
	logic [`BP_PC_W-1:0] commit1_pc;
	logic                commit1_taken;
	logic [`BP_PC_W-1:0] fetch_pc_a;
	logic [`BP_PC_W-1:0] fetch_pc_b;
	logic [`BP_PC_W-1:0] fetch_pc_c;
	logic [`BP_PC_W-1:0] fetch_pc_d;
	logic                predict_taken_a;
	logic                predict_taken_b;
	logic                predict_taken_c;
	logic                predict_taken_d;
	logic                update_dropped;

	// ========================================================================
	// reference model state
	// ========================================================================

	bp_pkg::bht_state_t m_bht [0:511];
	logic [2:0]  m_hist;
	// filter output register
	logic        m_f0_v;
	logic        m_f1_v;
	logic        m_f0_tk;
	logic        m_f1_tk;
	logic [31:0] m_f0_pc;
	logic [31:0] m_f1_pc;
	// queue pointers count up without wrapping
	logic [31:0] m_q_pc [0:DEPTH-1];
	logic        m_q_tk [0:DEPTH-1];
	int          m_head;
	int          m_tail;
	// pop register and drop flag
	logic        m_pop_v;
	logic        m_pop_tk;
	logic [31:0] m_pop_pc;
	logic        m_drop;
	// scratch for one model step
	int          occ;
	int          free;
	int          idx;
	logic        do_pop;
	logic        acc0;
	logic        acc1;
	logic        keep1;
	// stimulus bookkeeping
	int          cycle_cnt;
	int          stim_cnt;
	int          stall_len;
	logic [31:0] seed;
	logic [31:0] x_pc;
	logic [31:0] y_pc;

	bp_predictor i_bp_predictor (
		.clk(clk), .rst(rst), .en(en),
		.commit0_valid(commit0_valid), .commit0_pc(commit0_pc), .commit0_taken(commit0_taken),
		.commit1_valid(commit1_valid), .commit1_pc(commit1_pc), .commit1_taken(commit1_taken),
		.fetch_pc_a(fetch_pc_a), .fetch_pc_b(fetch_pc_b),
		.fetch_pc_c(fetch_pc_c), .fetch_pc_d(fetch_pc_d),
		.predict_taken_a(predict_taken_a), .predict_taken_b(predict_taken_b),
		.predict_taken_c(predict_taken_c), .predict_taken_d(predict_taken_d),
		.update_dropped(update_dropped)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// 16 word-aligned addresses in a 64 byte window
	function automatic logic [31:0] pick_pc();
		logic [31:0] r;
		r = rand32();
		return 32'h0000_4a00 + {26'd0, r[27:24], 2'b00};
	endfunction

	// address bits 8:2 followed by history bits 2:1
	function automatic int model_index(input logic [31:0] pc, input logic [2:0] hist);
		return {pc[8:2], hist[2:1]};
	endfunction

	// saturating walk along strong_nt, weak_nt, weak_t, strong_t
	function automatic bp_pkg::bht_state_t model_step(input bp_pkg::bht_state_t cur,
			input logic taken);
		if (taken && cur != bp_pkg::strong_t)
			return bp_pkg::bht_state_t'(cur + 1);
		if (!taken && cur != bp_pkg::strong_nt)
			return bp_pkg::bht_state_t'(cur - 1);
		return cur;
	endfunction

	function automatic logic model_predict(input logic [31:0] pc);
		bp_pkg::bht_state_t st;
		st = m_bht[model_index(pc, m_hist)];
		return en && (st == bp_pkg::weak_t || st == bp_pkg::strong_t);
	endfunction

	task automatic stop_fail();
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			stop_fail();
		end
	endtask

	// ========================================================================
	// model update from the inputs as they stood before the edge
	// ========================================================================

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run hung: cycle limit of %0d reached", TIMEOUT_CYCLES);
			stop_fail();
		end
		if (rst) begin
			for (int i = 0; i < 512; i++)
				m_bht[i] = bp_pkg::weak_nt;
			m_hist = '0;
			m_head = 0;
			m_tail = 0;
			m_f0_v = 1'b0;
			m_f1_v = 1'b0;
			m_pop_v = 1'b0;
			m_drop = 1'b0;
		end else begin
			// table consumes the entry popped on the previous edge
			if (m_pop_v) begin
				idx = model_index(m_pop_pc, m_hist);
				m_bht[idx] = model_step(m_bht[idx], m_pop_tk);
				m_hist = {m_hist[1:0], m_pop_tk};
			end
			occ = m_tail - m_head;
			do_pop = en && (occ != 0);
			// a slot freed by the pop counts for the push
			free = DEPTH - occ + (do_pop ? 1 : 0);
			acc0 = m_f0_v && (free >= 1);
			acc1 = m_f1_v && (free >= 2);
			m_drop = (m_f0_v && !acc0) || (m_f1_v && !acc1);
			// pop reads before the push can overwrite the head slot
			m_pop_v = do_pop;
			if (do_pop) begin
				m_pop_pc = m_q_pc[m_head % DEPTH];
				m_pop_tk = m_q_tk[m_head % DEPTH];
				m_head++;
			end
			if (acc0) begin
				m_q_pc[m_tail % DEPTH] = m_f0_pc;
				m_q_tk[m_tail % DEPTH] = m_f0_tk;
				m_tail++;
			end
			if (acc1) begin
				m_q_pc[m_tail % DEPTH] = m_f1_pc;
				m_q_tk[m_tail % DEPTH] = m_f1_tk;
				m_tail++;
			end
			// slot 1 lies in the shadow of a taken slot 0
			keep1 = commit1_valid && !(commit0_valid && commit0_taken);
			m_f0_v = commit0_valid || keep1;
			m_f1_v = commit0_valid && keep1;
			m_f0_pc = commit0_valid ? commit0_pc : commit1_pc;
			m_f0_tk = commit0_valid ? commit0_taken : commit1_taken;
			m_f1_pc = commit1_pc;
			m_f1_tk = commit1_taken;
		end
	end

	// outputs settle half a cycle after the inputs change
	always @(negedge clk) begin
		if (!rst) begin
			check_bit("predict_taken_a", model_predict(fetch_pc_a), predict_taken_a);
			check_bit("predict_taken_b", model_predict(fetch_pc_b), predict_taken_b);
			check_bit("predict_taken_c", model_predict(fetch_pc_c), predict_taken_c);
			check_bit("predict_taken_d", model_predict(fetch_pc_d), predict_taken_d);
			check_bit("update_dropped", m_drop, update_dropped);
		end
	end

	task automatic drive(input logic en_val, input logic v0, input logic [31:0] pc0,
			input logic t0, input logic v1, input logic [31:0] pc1, input logic t1,
			input logic [31:0] fa);
		@(posedge clk);
		en <= en_val;
		commit0_valid <= v0;
		commit0_pc <= pc0;
		commit0_taken <= t0;
		commit1_valid <= v1;
		commit1_pc <= pc1;
		commit1_taken <= t1;
		fetch_pc_a <= fa;
		fetch_pc_b <= pick_pc();
		fetch_pc_c <= pick_pc();
		fetch_pc_d <= pick_pc();
		stim_cnt++;
	endtask

	// each slot valid with pct percent and a random direction
	task automatic random_cycle(input logic en_val, input int pct);
		logic [31:0] r;
		r = rand32();
		drive(en_val, r[31:24] % 100 < pct, pick_pc(), r[3], r[23:16] % 100 < pct,
			pick_pc(), r[5], pick_pc());
	endtask

	initial begin
		seed = 32'hb1e8;
		cycle_cnt = 0;
		stim_cnt = 0;
		stall_len = 0;
		rst = 1'b1;
		en = 1'b1;
		{commit0_valid, commit0_taken, commit1_valid, commit1_taken} = '0;
		{commit0_pc, commit1_pc} = '0;
		{fetch_pc_a, fetch_pc_b, fetch_pc_c, fetch_pc_d} = '0;
		x_pc = 32'h0000_4a0c;
		y_pc = 32'h0000_4a24;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// phase 1 sends two taken at history zero and three not-taken that clear the history
		drive(1'b1, 1'b1, x_pc, 1'b1, 1'b0, y_pc, 1'b0, x_pc);
		repeat (3) drive(1'b1, 1'b0, x_pc, 1'b0, 1'b0, y_pc, 1'b0, x_pc);
		drive(1'b1, 1'b1, x_pc, 1'b1, 1'b0, y_pc, 1'b0, x_pc);
		drive(1'b1, 1'b1, y_pc, 1'b0, 1'b1, y_pc, 1'b0, x_pc);
		drive(1'b1, 1'b0, x_pc, 1'b0, 1'b1, y_pc, 1'b0, x_pc);
		repeat (10) drive(1'b1, 1'b0, x_pc, 1'b0, 1'b0, y_pc, 1'b0, x_pc);
		@(negedge clk);
		check_bit("predict_taken_a", 1'b1, predict_taken_a);
		while (stim_cnt < 100)
			random_cycle(1'b1, 0);

		// phase 2 is random traffic with the predictor enabled
		repeat (1400) random_cycle(1'b1, 40);
		// phase 3 stalls for a random length at the start of each block
		for (int blk = 0; blk < 30; blk++) begin
			stall_len = rand32() % 12;
			for (int i = 0; i < 20; i++)
				random_cycle(i >= stall_len, 50);
		end
		// phase 4 pushes dual commits into a stalled queue and then drains it
		for (int blk = 0; blk < 9; blk++) begin
			for (int i = 0; i < 40; i++)
				drive(1'b0, 1'b1, pick_pc(), 1'b0, 1'b1, pick_pc(),
					rand32() >= 32'h8000_0000, pick_pc());
			repeat (60) random_cycle(1'b1, 15);
		end
		// the last cycle was checked on the falling edge before this one
		@(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/bp_pkg.sv
verilog/bp_commit_filter.sv
verilog/bp_update_queue.sv
verilog/bp_history_table.sv
verilog/bp_predictor.sv
sim/bp_tb.sv

// ==== Bender.yml ====
package:
  name: bp_predictor

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bp_pkg.sv
      - verilog/bp_commit_filter.sv
      - verilog/bp_update_queue.sv
      - verilog/bp_history_table.sv
      - verilog/bp_predictor.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/bp_tb.sv
